// File: design/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define CACHE_SETS 16
`define CACHE_BLOCK_WORDS 4

// byte address width on both bus ports
`define CACHE_ADDR_W 32

// offset split into byte and word fields
`define CACHE_BYTE_OFF_W 2
`define CACHE_WORD_SEL_W $clog2(`CACHE_BLOCK_WORDS)

// set index and tag widths
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_TAG_W \
    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WORD_SEL_W - `CACHE_BYTE_OFF_W)

`endif

// File: design/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    // address fields
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_WORD_SEL_W-1:0] word_sel_t;

    // two ways only
    typedef logic way_t;

    // wishbone classic bundle from master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        addr_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_m2s_t;

    // wishbone classic bundle from slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    // tag store answer for the addressed set
    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_refill,
        st_respond
    } cache_state_e;

endpackage

// File: design/cache_tag_store.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_tag_store (
    input  logic                clk_i,
    input  logic                nreset_i,

    input  cache_pkg::index_t   lookup_index_i,
    input  cache_pkg::tag_t     lookup_tag_i,

    input  logic                fill_i,
    input  cache_pkg::way_t     fill_way_i,
    input  logic                mark_dirty_i,
    input  logic                touch_i,
    input  cache_pkg::way_t     touch_way_i,

    output cache_pkg::lookup_t  lookup_o
);

    cache_pkg::tag_t tag_r [`CACHE_SETS][2];
    logic [`CACHE_SETS-1:0][1:0] valid_r;
    logic [`CACHE_SETS-1:0][1:0] dirty_r;
    // names the way to evict next
    logic [`CACHE_SETS-1:0] lru_r;

    logic [1:0] way_hit;
    logic [1:0] set_valid;
    logic [1:0] set_dirty;
    cache_pkg::way_t victim_way;
    cache_pkg::way_t dirty_way;
    logic dirty_wr;

    assign set_valid = valid_r[lookup_index_i];
    assign set_dirty = dirty_r[lookup_index_i];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = set_valid[w] && (tag_r[lookup_index_i][w] == lookup_tag_i);
        end
    end

    // empty way first, else the lru choice
    always_comb begin
        if (!set_valid[0]) begin
            victim_way = 1'b0;
        end else if (!set_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_r[lookup_index_i];
        end
    end

    assign lookup_o.hit          = |way_hit;
    assign lookup_o.hit_way      = way_hit[1];
    assign lookup_o.victim_way   = victim_way;
    assign lookup_o.victim_dirty = set_valid[victim_way] && set_dirty[victim_way];
    assign lookup_o.victim_tag   = tag_r[lookup_index_i][victim_way];

    // a fill clears dirty unless a write lands with it
    assign dirty_way = fill_i ? fill_way_i : lookup_o.hit_way;
    assign dirty_wr  = fill_i || (mark_dirty_i && lookup_o.hit);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            valid_r <= '0;
            dirty_r <= '0;
            lru_r   <= '0;
        end else begin
            if (fill_i) begin
                valid_r[lookup_index_i][fill_way_i] <= 1'b1;
            end
            if (dirty_wr) begin
                dirty_r[lookup_index_i][dirty_way] <= mark_dirty_i;
            end
            if (touch_i) begin
                lru_r[lookup_index_i] <= ~touch_way_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_r[lookup_index_i][fill_way_i] <= lookup_tag_i;
        end
    end

endmodule

// File: design/cache_data_store.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_data_store (
    input  logic                  clk_i,

    input  cache_pkg::way_t       way_i,
    input  cache_pkg::index_t     index_i,
    input  cache_pkg::word_sel_t  word_sel_i,

    input  logic                  we_i,
    input  logic [3:0]            byte_mask_i,
    input  cache_pkg::word_t      wdata_i,

    output cache_pkg::word_t      rdata_o
);

    // set, way, word
    cache_pkg::word_t data_r [`CACHE_SETS][2][`CACHE_BLOCK_WORDS];

    cache_pkg::word_t cur_word;

    assign cur_word = data_r[index_i][way_i][word_sel_i];
    assign rdata_o  = cur_word;

    // only the enabled byte lanes change
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_mask_i[b]) begin
                    data_r[index_i][way_i][word_sel_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: design/cache_controller.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_controller (
    input  logic                  clk_i,
    input  logic                  nreset_i,

    // core side
    input  cache_pkg::wb_m2s_t    core_m2s_i,
    output cache_pkg::wb_s2m_t    core_s2m_o,

    // memory side
    output cache_pkg::wb_m2s_t    mem_m2s_o,
    input  cache_pkg::wb_s2m_t    mem_s2m_i,

    // tag store
    input  cache_pkg::lookup_t    lookup_i,
    output cache_pkg::index_t     lookup_index_o,
    output cache_pkg::tag_t       lookup_tag_o,
    output logic                  fill_o,
    output cache_pkg::way_t       fill_way_o,
    output logic                  mark_dirty_o,
    output logic                  touch_o,
    output cache_pkg::way_t       touch_way_o,

    // data store
    output cache_pkg::way_t       ds_way_o,
    output cache_pkg::index_t     ds_index_o,
    output cache_pkg::word_sel_t  ds_word_sel_o,
    output logic                  ds_we_o,
    output logic [3:0]            ds_byte_mask_o,
    output cache_pkg::word_t      ds_wdata_o,
    input  cache_pkg::word_t      ds_rdata_i
);

    cache_pkg::cache_state_e state_r, state_n;
    cache_pkg::word_sel_t beat_r, beat_n;

    cache_pkg::wb_m2s_t req_r;
    cache_pkg::lookup_t lookup_r;

    cache_pkg::tag_t req_tag;
    cache_pkg::index_t req_index;
    cache_pkg::word_sel_t req_word;
    cache_pkg::way_t target_way;
    cache_pkg::tag_t mem_tag;

    logic core_req;
    logic last_beat;
    logic mem_busy;

    assign core_req  = core_m2s_i.cyc && core_m2s_i.stb;
    assign last_beat = beat_r == cache_pkg::word_sel_t'(`CACHE_BLOCK_WORDS - 1);
    assign mem_busy  = (state_r == cache_pkg::st_write_back) ||
                       (state_r == cache_pkg::st_refill);

    // request address fields
    assign req_tag   = req_r.adr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index = req_r.adr[`CACHE_BYTE_OFF_W + `CACHE_WORD_SEL_W +: `CACHE_INDEX_W];
    assign req_word  = req_r.adr[`CACHE_BYTE_OFF_W +: `CACHE_WORD_SEL_W];

    // on a miss the victim way takes the new block
    assign target_way = lookup_r.hit ? lookup_r.hit_way : lookup_r.victim_way;

    always_comb begin
        state_n = state_r;
        beat_n  = beat_r;
        case (state_r)
            cache_pkg::st_idle: begin
                if (core_req) begin
                    state_n = cache_pkg::st_lookup;
                end
            end
            cache_pkg::st_lookup: begin
                beat_n = '0;
                if (lookup_i.hit) begin
                    state_n = cache_pkg::st_respond;
                end else if (lookup_i.victim_dirty) begin
                    state_n = cache_pkg::st_write_back;
                end else begin
                    state_n = cache_pkg::st_refill;
                end
            end
            cache_pkg::st_write_back: begin
                if (mem_s2m_i.ack) begin
                    beat_n = beat_r + 1'b1;
                    if (last_beat) begin
                        state_n = cache_pkg::st_refill;
                    end
                end
            end
            cache_pkg::st_refill: begin
                if (mem_s2m_i.ack) begin
                    beat_n = beat_r + 1'b1;
                    if (last_beat) begin
                        state_n = cache_pkg::st_respond;
                    end
                end
            end
            cache_pkg::st_respond: begin
                state_n = cache_pkg::st_idle;
            end
            default: begin
                state_n = cache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r <= cache_pkg::st_idle;
            beat_r  <= '0;
        end else begin
            state_r <= state_n;
            beat_r  <= beat_n;
        end
    end

    // request and lookup held for the whole access
    always_ff @(posedge clk_i) begin
        if ((state_r == cache_pkg::st_idle) && core_req) begin
            req_r <= core_m2s_i;
        end
        if (state_r == cache_pkg::st_lookup) begin
            lookup_r <= lookup_i;
        end
    end

    assign lookup_index_o = req_index;
    assign lookup_tag_o   = req_tag;

    // tag written with the last refill word
    assign fill_o       = (state_r == cache_pkg::st_refill) && mem_s2m_i.ack && last_beat;
    assign fill_way_o   = target_way;
    assign mark_dirty_o = (state_r == cache_pkg::st_respond) && req_r.we;
    assign touch_o      = state_r == cache_pkg::st_respond;
    assign touch_way_o  = target_way;

    // beat word to the store while on the bus and the core word otherwise
    always_comb begin
        ds_way_o   = target_way;
        ds_index_o = req_index;
        if (mem_busy) begin
            ds_word_sel_o  = beat_r;
            ds_we_o        = (state_r == cache_pkg::st_refill) && mem_s2m_i.ack;
            ds_byte_mask_o = 4'hf;
            ds_wdata_o     = mem_s2m_i.dat;
        end else begin
            ds_word_sel_o  = req_word;
            ds_we_o        = (state_r == cache_pkg::st_respond) && req_r.we;
            ds_byte_mask_o = req_r.sel;
            ds_wdata_o     = req_r.dat;
        end
    end

    // write-back goes to the victim's block address
    assign mem_tag = (state_r == cache_pkg::st_write_back) ? lookup_r.victim_tag : req_tag;

    assign mem_m2s_o.cyc = mem_busy;
    assign mem_m2s_o.stb = mem_busy;
    assign mem_m2s_o.we  = state_r == cache_pkg::st_write_back;
    assign mem_m2s_o.adr = {mem_tag, req_index, beat_r, {`CACHE_BYTE_OFF_W{1'b0}}};
    assign mem_m2s_o.dat = ds_rdata_i;
    assign mem_m2s_o.sel = 4'hf;

    assign core_s2m_o.ack = state_r == cache_pkg::st_respond;
    assign core_s2m_o.dat = ds_rdata_i;

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                clk_i,
    input  logic                nreset_i,

    input  cache_pkg::wb_m2s_t  core_m2s_i,
    output cache_pkg::wb_s2m_t  core_s2m_o,

    output cache_pkg::wb_m2s_t  mem_m2s_o,
    input  cache_pkg::wb_s2m_t  mem_s2m_i
);

    cache_pkg::lookup_t   lookup;
    cache_pkg::index_t    lookup_index;
    cache_pkg::tag_t      lookup_tag;
    logic                 fill;
    cache_pkg::way_t      fill_way;
    logic                 mark_dirty;
    logic                 touch;
    cache_pkg::way_t      touch_way;

    cache_pkg::way_t      ds_way;
    cache_pkg::index_t    ds_index;
    cache_pkg::word_sel_t ds_word_sel;
    logic                 ds_we;
    logic [3:0]           ds_byte_mask;
    cache_pkg::word_t     ds_wdata;
    cache_pkg::word_t     ds_rdata;

    cache_tag_store u_cache_tag_store (
        .clk_i          (clk_i),
        .nreset_i       (nreset_i),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .mark_dirty_i   (mark_dirty),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .lookup_o       (lookup)
    );

    cache_data_store u_cache_data_store (
        .clk_i       (clk_i),
        .way_i       (ds_way),
        .index_i     (ds_index),
        .word_sel_i  (ds_word_sel),
        .we_i        (ds_we),
        .byte_mask_i (ds_byte_mask),
        .wdata_i     (ds_wdata),
        .rdata_o     (ds_rdata)
    );

    cache_controller u_cache_controller (
        .clk_i          (clk_i),
        .nreset_i       (nreset_i),
        .core_m2s_i     (core_m2s_i),
        .core_s2m_o     (core_s2m_o),
        .mem_m2s_o      (mem_m2s_o),
        .mem_s2m_i      (mem_s2m_i),
        .lookup_i       (lookup),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .mark_dirty_o   (mark_dirty),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .ds_way_o       (ds_way),
        .ds_index_o     (ds_index),
        .ds_word_sel_o  (ds_word_sel),
        .ds_we_o        (ds_we),
        .ds_byte_mask_o (ds_byte_mask),
        .ds_wdata_o     (ds_wdata),
        .ds_rdata_i     (ds_rdata)
    );

endmodule

// File: testbench/tb_wb_memory.sv
`timescale 1ns/1ns

module tb_wb_memory (
    input  logic                clk_i,
    input  logic                nreset_i,
    input  cache_pkg::wb_m2s_t  m2s_i,
    output cache_pkg::wb_s2m_t  s2m_o
);

    // only written words are stored
    cache_pkg::word_t mem_r [cache_pkg::addr_t];
    cache_pkg::addr_t write_log [256];
    int read_beats;
    int write_beats;
    logic [15:0] lfsr_r;
    int wait_r;
    logic busy_r;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic cache_pkg::word_t read_word(input cache_pkg::addr_t a);
        if (mem_r.exists(a)) begin
            return mem_r[a];
        end
        return a + 32'h1000_0000;
    endfunction

    always @(posedge clk_i) begin
        logic [15:0] s1;
        logic [15:0] s2;
        cache_pkg::addr_t key;
        cache_pkg::word_t w;
        key = {m2s_i.adr[31:2], 2'b00};
        if (nreset_i) begin
            s2m_o       <= '0;
            busy_r      = 1'b0;
            wait_r      = 0;
            lfsr_r      = 16'd36189;
            read_beats  = 0;
            write_beats = 0;
        end else if (s2m_o.ack) begin
            // beat completes at this edge
            s2m_o.ack <= 1'b0;
            busy_r = 1'b0;
            if (m2s_i.we) begin
                w = read_word(key);
                for (int b = 0; b < 4; b++) begin
                    if (m2s_i.sel[b]) begin
                        w[8*b +: 8] = m2s_i.dat[8*b +: 8];
                    end
                end
                mem_r[key] = w;
                write_log[write_beats % 256] = m2s_i.adr;
                write_beats = write_beats + 1;
            end else begin
                read_beats = read_beats + 1;
            end
        end else if (m2s_i.cyc && m2s_i.stb) begin
            if (!busy_r) begin
                // two bits give a delay of 0 to 3 cycles
                s1 = lfsr_next(lfsr_r);
                s2 = lfsr_next(s1);
                lfsr_r = s2;
                busy_r = 1'b1;
                wait_r = int'({s1[0], s2[0]});
            end else if (wait_r > 0) begin
                wait_r = wait_r - 1;
            end else begin
                s2m_o.ack <= 1'b1;
                s2m_o.dat <= read_word(key);
            end
        end
    end

endmodule

// File: testbench/tb_cache_top.sv
`timescale 1ns/1ns

module tb_cache_top;

    localparam int clk_period = 10;
    localparam int reset_cycles = 16;
    localparam int num_entries = 24;
    localparam int cycles_per_entry = 60;

    typedef enum logic [1:0] {
        exp_hit,
        exp_miss,
        exp_dirty
    } exp_class_e;

    typedef struct packed {
        logic             we;
        cache_pkg::addr_t adr;
        cache_pkg::word_t dat;
        logic [3:0]       sel;
        exp_class_e       kind;
        cache_pkg::addr_t wb_adr;
    } entry_t;

    logic clk;
    logic nreset;
    cache_pkg::wb_m2s_t core_m2s;
    cache_pkg::wb_s2m_t core_s2m;
    cache_pkg::wb_m2s_t mem_m2s;
    cache_pkg::wb_s2m_t mem_s2m;

    entry_t table_r [num_entries];
    cache_pkg::word_t shadow [cache_pkg::addr_t];
    int check_total;
    int error_total;

    cache_top u_cache_top (
        .clk_i      (clk),
        .nreset_i   (nreset),
        .core_m2s_i (core_m2s),
        .core_s2m_o (core_s2m),
        .mem_m2s_o  (mem_m2s),
        .mem_s2m_i  (mem_s2m)
    );

    tb_wb_memory u_wb_memory (
        .clk_i    (clk),
        .nreset_i (nreset),
        .m2s_i    (mem_m2s),
        .s2m_o    (mem_s2m)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #((reset_cycles + num_entries * cycles_per_entry) * clk_period);
        $display("timeout: the core port never returned ack");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic load_table();
        // set 0 takes a cold miss, hits, a byte write and a dirty eviction
        table_r[0]  = '{1'b0, 32'h0000_1004, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[1]  = '{1'b0, 32'h0000_1004, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[2]  = '{1'b0, 32'h0000_100c, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[3]  = '{1'b1, 32'h0000_1008, 32'haabb_ccdd, 4'h5, exp_hit, 32'h0};
        table_r[4]  = '{1'b0, 32'h0000_1008, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[5]  = '{1'b0, 32'h0000_2000, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[6]  = '{1'b0, 32'h0000_3004, 32'h0, 4'hf, exp_dirty, 32'h0000_1000};
        table_r[7]  = '{1'b0, 32'h0000_1008, 32'h0, 4'hf, exp_miss, 32'h0};
        // set 1 shows lru keeping the reread block
        table_r[8]  = '{1'b0, 32'h0000_4010, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[9]  = '{1'b1, 32'h0000_5014, 32'h1234_5678, 4'hf, exp_miss, 32'h0};
        table_r[10] = '{1'b0, 32'h0000_4010, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[11] = '{1'b0, 32'h0000_6018, 32'h0, 4'hf, exp_dirty, 32'h0000_5010};
        table_r[12] = '{1'b0, 32'h0000_401c, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[13] = '{1'b0, 32'h0000_5014, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[14] = '{1'b0, 32'h0000_6018, 32'h0, 4'hf, exp_miss, 32'h0};
        // sets 2 and 15
        table_r[15] = '{1'b1, 32'h0000_7020, 32'hee00_0000, 4'h8, exp_miss, 32'h0};
        table_r[16] = '{1'b0, 32'h0000_7020, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[17] = '{1'b0, 32'h0000_7ff0, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[18] = '{1'b0, 32'h0000_8ff4, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[19] = '{1'b1, 32'h0000_90f8, 32'h0000_5a5a, 4'h3, exp_miss, 32'h0};
        table_r[20] = '{1'b0, 32'h0000_90f8, 32'h0, 4'hf, exp_hit, 32'h0};
        table_r[21] = '{1'b0, 32'h0000_7ff0, 32'h0, 4'hf, exp_miss, 32'h0};
        table_r[22] = '{1'b0, 32'h0000_a0f0, 32'h0, 4'hf, exp_dirty, 32'h0000_90f0};
        table_r[23] = '{1'b0, 32'h0000_90f8, 32'h0, 4'hf, exp_miss, 32'h0};
    endtask

    // untouched words hold address plus 0x10000000
    function automatic cache_pkg::word_t shadow_read(input cache_pkg::addr_t a);
        cache_pkg::addr_t key;
        key = {a[31:2], 2'b00};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return key + 32'h1000_0000;
    endfunction

    task automatic shadow_write(input cache_pkg::addr_t a, input cache_pkg::word_t d,
                                input logic [3:0] sel);
        cache_pkg::word_t w;
        w = shadow_read(a);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        shadow[{a[31:2], 2'b00}] = w;
    endtask

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        check_total++;
        if (got !== exp) begin
            error_total++;
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input cache_pkg::addr_t got, input cache_pkg::addr_t exp,
                              input string what);
        check_total++;
        if (got !== exp) begin
            error_total++;
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_total++;
        if (got != exp) begin
            error_total++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one core access started on a falling edge
    task automatic run_entry(input entry_t e, input int idx);
        int rd0;
        int wr0;
        int waited;
        int bus_cycles;
        cache_pkg::word_t got;
        rd0 = u_wb_memory.read_beats;
        wr0 = u_wb_memory.write_beats;
        core_m2s.cyc = 1'b1;
        core_m2s.stb = 1'b1;
        core_m2s.we  = e.we;
        core_m2s.adr = e.adr;
        core_m2s.dat = e.dat;
        core_m2s.sel = e.sel;
        waited = 0;
        bus_cycles = 0;
        do begin
            @(negedge clk);
            waited++;
            if (mem_m2s.cyc || mem_m2s.stb) begin
                bus_cycles++;
            end
        end while (!core_s2m.ack);
        got = core_s2m.dat;
        core_m2s.cyc = 1'b0;
        core_m2s.stb = 1'b0;
        core_m2s.we  = 1'b0;
        @(negedge clk);

        if (e.we) begin
            shadow_write(e.adr, e.dat, e.sel);
        end else begin
            check_word(got, shadow_read(e.adr), $sformatf("entry %0d read data", idx));
        end
        case (e.kind)
            exp_hit: begin
                check_count(waited, 2, $sformatf("entry %0d hit latency", idx));
                check_count(bus_cycles, 0, $sformatf("entry %0d memory bus cycles", idx));
                check_count(u_wb_memory.read_beats - rd0, 0, $sformatf("entry %0d reads", idx));
            end
            default: begin
                check_count(u_wb_memory.read_beats - rd0, 4, $sformatf("entry %0d reads", idx));
            end
        endcase
        if (e.kind == exp_dirty) begin
            check_count(u_wb_memory.write_beats - wr0, 4, $sformatf("entry %0d writes", idx));
            for (int k = 0; k < 4; k++) begin
                check_addr(u_wb_memory.write_log[(wr0 + k) % 256], e.wb_adr + 4 * k,
                           $sformatf("entry %0d write-back beat %0d", idx, k));
            end
        end else begin
            check_count(u_wb_memory.write_beats - wr0, 0, $sformatf("entry %0d writes", idx));
        end
    endtask

    initial begin
        check_total = 0;
        error_total = 0;
        core_m2s = '0;
        nreset = 1'b1;
        load_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        nreset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < num_entries; i++) begin
            run_entry(table_r[i], i);
        end
        $display("checks: %0d, errors: %0d", check_total, error_total);
        if (error_total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_controller.sv
design/cache_top.sv
testbench/tb_wb_memory.sv
testbench/tb_cache_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
